//--- lane_cfg_pkg.sv
// Lane configuration constants
// Sizes of the element datapath, the register file and the multiplier
`default_nettype none

package lane_cfg_pkg;

  // Element datapath width
  localparam int unsigned ELEN = 64;

  // Register file geometry
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned WORDS_PER_VREG = 8;
  localparam int unsigned VREG_W         = 3;

  // Word address is register number on top, word index below
  localparam int unsigned VADDR_W = 6;

  // Vector length, 1 to WORDS_PER_VREG words
  localparam int unsigned VL_W = 4;

  // Multiplier latency in cycles
  localparam int unsigned MUL_STAGES = 2;

endpackage

`default_nettype wire

//--- lane_insn_pkg.sv
// Lane instruction definitions
// Operation codes, element widths and the element word views
`default_nettype none

package lane_insn_pkg;

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_XOR   = 3'd3,
    OP_MUL   = 3'd4,
    OP_STORE = 3'd5
  } lane_op_e;

  // Element width inside one word
  typedef enum logic {
    SEW_32 = 1'b0,
    SEW_64 = 1'b1
  } sew_e;

  // One word as a single 64-bit element or as two 32-bit elements
  typedef union packed {
    logic [lane_cfg_pkg::ELEN-1:0]          e64;
    logic [1:0][lane_cfg_pkg::ELEN/2-1:0]   e32;
  } elem_word_u;

  // Operations executed by the integer ALU
  function automatic logic is_alu_op(lane_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};
  endfunction

endpackage

`default_nettype wire

//--- lane_alu.sv
// Integer ALU of the lane
// Add, subtract, AND and XOR on element words, one output register
`default_nettype none

module lane_alu (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                op_valid_i,
  output logic                                op_ready_o,
  input  lane_insn_pkg::lane_op_e             op_i,
  input  lane_insn_pkg::sew_e                 sew_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       a_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       b_i,
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    dst_i,
  output logic                                res_valid_o,
  input  logic                                res_ready_i,
  output logic [lane_cfg_pkg::VADDR_W-1:0]    res_addr_o,
  output logic [lane_cfg_pkg::ELEN-1:0]       res_data_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  elem_word_u          a_w;
  elem_word_u          b_w;
  elem_word_u          r_w;
  logic                res_valid_q;
  logic [VADDR_W-1:0]  res_addr_q;
  logic [ELEN-1:0]     res_data_q;
  logic                op_fire;

  assign a_w = a_i;
  assign b_w = b_i;

  // Output register empty or drained this cycle
  assign op_ready_o = ~res_valid_q | res_ready_i;
  assign op_fire    = op_valid_i & op_ready_o;

  always_comb begin
    r_w = '0;
    case (op_i)
      OP_ADD: begin
        r_w.e64 = a_w.e64 + b_w.e64;
        // No carry across the halves
        if (sew_i == SEW_32) begin
          for (int i = 0; i < 2; i++) begin
            r_w.e32[i] = a_w.e32[i] + b_w.e32[i];
          end
        end
      end
      OP_SUB: begin
        r_w.e64 = a_w.e64 - b_w.e64;
        if (sew_i == SEW_32) begin
          for (int i = 0; i < 2; i++) begin
            r_w.e32[i] = a_w.e32[i] - b_w.e32[i];
          end
        end
      end
      // Bitwise ops look the same in both widths
      OP_AND:  r_w.e64 = a_w.e64 & b_w.e64;
      OP_XOR:  r_w.e64 = a_w.e64 ^ b_w.e64;
      default: r_w = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (op_fire) begin
      res_addr_q <= dst_i;
      res_data_q <= r_w;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (op_fire) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_addr_o  = res_addr_q;
  assign res_data_o  = res_data_q;

endmodule

`default_nettype wire

//--- lane_mul.sv
// Pipelined integer multiplier of the lane
// Partial products in the first stage, low product bits in the second
`default_nettype none

module lane_mul (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                op_valid_i,
  output logic                                op_ready_o,
  input  lane_insn_pkg::lane_op_e             op_i,
  input  lane_insn_pkg::sew_e                 sew_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       a_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       b_i,
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    dst_i,
  output logic                                res_valid_o,
  input  logic                                res_ready_i,
  output logic [lane_cfg_pkg::VADDR_W-1:0]    res_addr_o,
  output logic [lane_cfg_pkg::ELEN-1:0]       res_data_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  elem_word_u                        a_w;
  elem_word_u                        b_w;
  logic [MUL_STAGES-1:0]             vld_q;
  logic [MUL_STAGES-1:0][VADDR_W-1:0] dst_q;
  sew_e                              sew_s1_q;
  // Stage 1 partial products
  logic [ELEN-1:0]                   pp_ll_q;
  logic [ELEN/2-1:0]                 pp_mid_q;
  logic [ELEN/2-1:0]                 pp_hh_q;
  // Stage 2 result
  logic [ELEN-1:0]                   res_data_q;
  logic                              stall;

  assign a_w = a_i;
  assign b_w = b_i;

  // Whole pipe freezes on a held result
  assign stall      = vld_q[MUL_STAGES-1] & ~res_ready_i;
  assign op_ready_o = ~stall;

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      pp_ll_q  <= a_w.e32[0] * b_w.e32[0];
      // Only the low half of the cross terms reaches the result
      pp_mid_q <= a_w.e32[0] * b_w.e32[1] + a_w.e32[1] * b_w.e32[0];
      pp_hh_q  <= a_w.e32[1] * b_w.e32[1];
      sew_s1_q <= sew_i;
      if (sew_s1_q == SEW_64) begin
        res_data_q <= pp_ll_q + {pp_mid_q, {(ELEN/2){1'b0}}};
      end else begin
        res_data_q <= {pp_hh_q, pp_ll_q[ELEN/2-1:0]};
      end
      dst_q <= {dst_q[MUL_STAGES-2:0], dst_i};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else if (!stall) begin
      // Only multiplies enter the pipe
      vld_q <= {vld_q[MUL_STAGES-2:0], op_valid_i & (op_i == OP_MUL)};
    end
  end

  assign res_valid_o = vld_q[MUL_STAGES-1];
  assign res_addr_o  = dst_q[MUL_STAGES-1];
  assign res_data_o  = res_data_q;

endmodule

`default_nettype wire

//--- lane_vrf.sv
// Vector register file of the lane
// Two combinational read ports and one write port shared by the
// multiplier, the ALU and the load port under fixed priority
`default_nettype none

module lane_vrf (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Reads
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    rd_addr_a_i,
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    rd_addr_b_i,
  output logic [lane_cfg_pkg::ELEN-1:0]       rd_data_a_o,
  output logic [lane_cfg_pkg::ELEN-1:0]       rd_data_b_o,
  // Multiplier results
  input  logic                                mul_valid_i,
  output logic                                mul_ready_o,
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    mul_addr_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       mul_data_i,
  // ALU results
  input  logic                                alu_valid_i,
  output logic                                alu_ready_o,
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    alu_addr_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       alu_data_i,
  // Load results
  input  logic                                ld_valid_i,
  output logic                                ld_ready_o,
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    ld_addr_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       ld_wdata_i,
  // One pulse per execution result written
  output logic                                wr_done_o
);

  import lane_cfg_pkg::*;

  logic [ELEN-1:0]     mem_q [NR_VREGS*WORDS_PER_VREG];
  logic                wr_en;
  logic [VADDR_W-1:0]  wr_addr;
  logic [ELEN-1:0]     wr_data;

  assign rd_data_a_o = mem_q[rd_addr_a_i];
  assign rd_data_b_o = mem_q[rd_addr_b_i];

  // Multiplier first, ALU second, load last
  assign mul_ready_o = 1'b1;
  assign alu_ready_o = ~mul_valid_i;
  assign ld_ready_o  = ~mul_valid_i & ~alu_valid_i;

  always_comb begin
    wr_en   = 1'b1;
    wr_addr = ld_addr_i;
    wr_data = ld_wdata_i;
    if (mul_valid_i) begin
      wr_addr = mul_addr_i;
      wr_data = mul_data_i;
    end else if (alu_valid_i) begin
      wr_addr = alu_addr_i;
      wr_data = alu_data_i;
    end else if (!ld_valid_i) begin
      wr_en = 1'b0;
    end
  end

  // Loads are not counted
  assign wr_done_o = mul_valid_i | alu_valid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NR_VREGS*WORDS_PER_VREG; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- lane_sequencer.sv
// Lane sequencer
// Accepts one instruction, walks its elements and dispatches them to the
// execution units or streams them out as store operands
`default_nettype none

module lane_sequencer (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Instruction request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  lane_insn_pkg::lane_op_e             req_op_i,
  input  lane_insn_pkg::sew_e                 req_sew_i,
  input  logic [lane_cfg_pkg::VREG_W-1:0]     req_vd_i,
  input  logic [lane_cfg_pkg::VREG_W-1:0]     req_vs1_i,
  input  logic [lane_cfg_pkg::VREG_W-1:0]     req_vs2_i,
  input  logic [lane_cfg_pkg::VL_W-1:0]       req_vl_i,
  output logic                                resp_done_o,
  // Register file reads
  output logic [lane_cfg_pkg::VADDR_W-1:0]    rd_addr_a_o,
  output logic [lane_cfg_pkg::VADDR_W-1:0]    rd_addr_b_o,
  input  logic [lane_cfg_pkg::ELEN-1:0]       rd_data_a_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       rd_data_b_i,
  // Issue to the ALU and the multiplier
  output logic                                alu_valid_o,
  input  logic                                alu_ready_i,
  output logic                                mul_valid_o,
  input  logic                                mul_ready_i,
  output lane_insn_pkg::lane_op_e             ex_op_o,
  output lane_insn_pkg::sew_e                 ex_sew_o,
  output logic [lane_cfg_pkg::ELEN-1:0]       ex_a_o,
  output logic [lane_cfg_pkg::ELEN-1:0]       ex_b_o,
  output logic [lane_cfg_pkg::VADDR_W-1:0]    ex_dst_o,
  // One pulse per result written back
  input  logic                                wr_done_i,
  // Store operand
  output logic                                st_valid_o,
  input  logic                                st_ready_i,
  output logic [lane_cfg_pkg::ELEN-1:0]       st_data_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  // Latched instruction
  lane_op_e                       op_q;
  sew_e                           sew_q;
  logic [VREG_W-1:0]              vd_q;
  logic [VREG_W-1:0]              vs1_q;
  logic [VREG_W-1:0]              vs2_q;
  logic [VL_W-1:0]                vl_q;

  // Walk state
  logic                           busy_q;
  logic                           walk_done_q;
  logic [VADDR_W-VREG_W-1:0]      idx_q;
  logic [VL_W-1:0]                pending_q;
  logic                           resp_done_q;

  // Store output register
  logic                           st_valid_q;
  logic [ELEN-1:0]                st_data_q;

  logic req_fire;
  logic issue_en;
  logic ex_fire;
  logic st_load;
  logic elem_fire;
  logic last_elem;
  logic done_cond;

  assign req_ready_o = ~busy_q;
  assign req_fire    = req_valid_i & req_ready_o;

  // Stores stream the register named by vs1
  assign rd_addr_a_o = {vs1_q, idx_q};
  assign rd_addr_b_o = {vs2_q, idx_q};

  assign issue_en    = busy_q & ~walk_done_q;
  assign alu_valid_o = issue_en & is_alu_op(op_q);
  assign mul_valid_o = issue_en & (op_q == OP_MUL);
  assign ex_fire     = (alu_valid_o & alu_ready_i) | (mul_valid_o & mul_ready_i);

  // Store register takes a word when empty or draining
  assign st_load   = issue_en & (op_q == OP_STORE) & (~st_valid_q | st_ready_i);
  assign elem_fire = ex_fire | st_load;
  assign last_elem = (VL_W'(idx_q) == vl_q - VL_W'(1));

  assign ex_op_o  = op_q;
  assign ex_sew_o = sew_q;
  assign ex_a_o   = rd_data_a_i;
  assign ex_b_o   = rd_data_b_i;
  assign ex_dst_o = {vd_q, idx_q};

  // Walk over, every result written, store register empty
  assign done_cond = busy_q & walk_done_q & (pending_q == '0) & ~st_valid_q;

  assign resp_done_o = resp_done_q;
  assign st_valid_o  = st_valid_q;
  assign st_data_o   = st_data_q;

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q  <= req_op_i;
      sew_q <= req_sew_i;
      vd_q  <= req_vd_i;
      vs1_q <= req_vs1_i;
      vs2_q <= req_vs2_i;
      vl_q  <= req_vl_i;
    end
    if (st_load) begin
      st_data_q <= rd_data_a_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      walk_done_q <= 1'b0;
      idx_q       <= '0;
      pending_q   <= '0;
      resp_done_q <= 1'b0;
      st_valid_q  <= 1'b0;
    end else begin
      resp_done_q <= done_cond;
      // Issued but not yet written results
      pending_q   <= pending_q + VL_W'(ex_fire) - VL_W'(wr_done_i);
      if (st_load) begin
        st_valid_q <= 1'b1;
      end else if (st_ready_i) begin
        st_valid_q <= 1'b0;
      end
      if (req_fire) begin
        busy_q      <= 1'b1;
        walk_done_q <= 1'b0;
        idx_q       <= '0;
      end else begin
        if (done_cond) begin
          busy_q <= 1'b0;
        end
        if (elem_fire) begin
          idx_q <= idx_q + 1'b1;
          if (last_elem) begin
            walk_done_q <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- lane.sv
// Integer vector lane
// Sequencer, ALU, multiplier and register file behind valid/ready ports
`default_nettype none

module lane (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Instruction request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  lane_insn_pkg::lane_op_e             req_op_i,
  input  lane_insn_pkg::sew_e                 req_sew_i,
  input  logic [lane_cfg_pkg::VREG_W-1:0]     req_vd_i,
  input  logic [lane_cfg_pkg::VREG_W-1:0]     req_vs1_i,
  input  logic [lane_cfg_pkg::VREG_W-1:0]     req_vs2_i,
  input  logic [lane_cfg_pkg::VL_W-1:0]       req_vl_i,
  output logic                                resp_done_o,
  // Load result
  input  logic                                ld_valid_i,
  output logic                                ld_ready_o,
  input  logic [lane_cfg_pkg::VADDR_W-1:0]    ld_addr_i,
  input  logic [lane_cfg_pkg::ELEN-1:0]       ld_wdata_i,
  // Store operand
  output logic                                st_valid_o,
  input  logic                                st_ready_i,
  output logic [lane_cfg_pkg::ELEN-1:0]       st_data_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  logic [VADDR_W-1:0]  rd_addr_a;
  logic [VADDR_W-1:0]  rd_addr_b;
  logic [ELEN-1:0]     rd_data_a;
  logic [ELEN-1:0]     rd_data_b;
  logic                alu_op_valid;
  logic                alu_op_ready;
  logic                mul_op_valid;
  logic                mul_op_ready;
  lane_op_e            ex_op;
  sew_e                ex_sew;
  logic [ELEN-1:0]     ex_a;
  logic [ELEN-1:0]     ex_b;
  logic [VADDR_W-1:0]  ex_dst;
  logic                wr_done;

  lane_sequencer u_sequencer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_sew_i   (req_sew_i),
    .req_vd_i    (req_vd_i),
    .req_vs1_i   (req_vs1_i),
    .req_vs2_i   (req_vs2_i),
    .req_vl_i    (req_vl_i),
    .resp_done_o (resp_done_o),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_data_a_i (rd_data_a),
    .rd_data_b_i (rd_data_b),
    .alu_valid_o (alu_op_valid),
    .alu_ready_i (alu_op_ready),
    .mul_valid_o (mul_op_valid),
    .mul_ready_i (mul_op_ready),
    .ex_op_o     (ex_op),
    .ex_sew_o    (ex_sew),
    .ex_a_o      (ex_a),
    .ex_b_o      (ex_b),
    .ex_dst_o    (ex_dst),
    .wr_done_i   (wr_done),
    .st_valid_o  (st_valid_o),
    .st_ready_i  (st_ready_i),
    .st_data_o   (st_data_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////////////////////

  logic                alu_res_valid;
  logic                alu_res_ready;
  logic [VADDR_W-1:0]  alu_res_addr;
  logic [ELEN-1:0]     alu_res_data;
  logic                mul_res_valid;
  logic                mul_res_ready;
  logic [VADDR_W-1:0]  mul_res_addr;
  logic [ELEN-1:0]     mul_res_data;

  lane_alu u_alu (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .op_valid_i  (alu_op_valid),
    .op_ready_o  (alu_op_ready),
    .op_i        (ex_op),
    .sew_i       (ex_sew),
    .a_i         (ex_a),
    .b_i         (ex_b),
    .dst_i       (ex_dst),
    .res_valid_o (alu_res_valid),
    .res_ready_i (alu_res_ready),
    .res_addr_o  (alu_res_addr),
    .res_data_o  (alu_res_data)
  );

  lane_mul u_mul (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .op_valid_i  (mul_op_valid),
    .op_ready_o  (mul_op_ready),
    .op_i        (ex_op),
    .sew_i       (ex_sew),
    .a_i         (ex_a),
    .b_i         (ex_b),
    .dst_i       (ex_dst),
    .res_valid_o (mul_res_valid),
    .res_ready_i (mul_res_ready),
    .res_addr_o  (mul_res_addr),
    .res_data_o  (mul_res_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register file and writeback
  ////////////////////////////////////////////////////////////////////////////

  lane_vrf u_vrf (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .mul_valid_i (mul_res_valid),
    .mul_ready_o (mul_res_ready),
    .mul_addr_i  (mul_res_addr),
    .mul_data_i  (mul_res_data),
    .alu_valid_i (alu_res_valid),
    .alu_ready_o (alu_res_ready),
    .alu_addr_i  (alu_res_addr),
    .alu_data_i  (alu_res_data),
    .ld_valid_i  (ld_valid_i),
    .ld_ready_o  (ld_ready_o),
    .ld_addr_i   (ld_addr_i),
    .ld_wdata_i  (ld_wdata_i),
    .wr_done_o   (wr_done)
  );

endmodule

`default_nettype wire

//--- lane_sva.sv
// Lane handshake checker
// Valid hold, busy request gating and reset state of the lane
`default_nettype none

module lane_sva (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input logic                           req_valid_i,
  input logic                           req_ready_i,
  input logic                           resp_done_i,
  input logic                           st_valid_i,
  input logic                           st_ready_i,
  input logic [lane_cfg_pkg::ELEN-1:0]  st_data_i,
  input logic                           alu_res_valid_i,
  input logic                           mul_res_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Set from accepted request to done pulse
  logic busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (req_valid_i && req_ready_i) begin
      busy_q <= 1'b1;
    end else if (resp_done_i) begin
      busy_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid held with stable data until the transfer
  ////////////////////////////////////////////////////////////////////////////

  a_st_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    st_valid_i && !st_ready_i |=> st_valid_i && $stable(st_data_i))
    else $error("store operand dropped or changed before its transfer");

  // No new request while an instruction is in flight
  a_busy_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_q && !resp_done_i |-> !req_ready_i)
    else $error("request ready raised while an instruction is busy");

  // Outputs and internal valids low under reset
  a_reset_low: assert property (@(posedge clk_i)
    !arst_n_i |-> !resp_done_i && !st_valid_i && !alu_res_valid_i && !mul_res_valid_i)
    else $error("valid or done output high during reset");

endmodule

bind lane lane_sva u_lane_sva (
  .clk_i           (clk_i),
  .arst_n_i        (arst_n_i),
  .req_valid_i     (req_valid_i),
  .req_ready_i     (req_ready_o),
  .resp_done_i     (resp_done_o),
  .st_valid_i      (st_valid_o),
  .st_ready_i      (st_ready_i),
  .st_data_i       (st_data_o),
  .alu_res_valid_i (alu_res_valid),
  .mul_res_valid_i (mul_res_valid)
);

`default_nettype wire

//--- tb_lane.sv
// Testbench of the integer vector lane
// Loads, ALU and multiplier ops and stores checked against a shadow register file
`default_nettype none

module tb_lane;

  timeunit 1ns;
  timeprecision 100ps;

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  // Run limit from loads plus instructions, each well under one step
  localparam int unsigned RESET_CYCLES    = 16;
  localparam int unsigned NR_STEPS        = 40;
  localparam int unsigned CYCLES_PER_STEP = 64;
  localparam int unsigned MAX_CYCLES      = RESET_CYCLES + NR_STEPS * CYCLES_PER_STEP;

  logic                clk;
  logic                arst_n;
  logic                req_valid;
  logic                req_ready;
  lane_op_e            req_op;
  sew_e                req_sew;
  logic [VREG_W-1:0]   req_vd;
  logic [VREG_W-1:0]   req_vs1;
  logic [VREG_W-1:0]   req_vs2;
  logic [VL_W-1:0]     req_vl;
  logic                resp_done;
  logic                ld_valid;
  logic                ld_ready;
  logic [VADDR_W-1:0]  ld_addr;
  logic [ELEN-1:0]     ld_wdata;
  logic                st_valid;
  logic                st_ready;
  logic [ELEN-1:0]     st_data;

  // Shadow registers and expected store words
  logic [ELEN-1:0]     shadow [NR_VREGS*WORDS_PER_VREG];
  logic [ELEN-1:0]     st_expect [$];
  logic [ELEN-1:0]     st_exp_word;
  integer              seed;
  integer              bp_seed;
  int                  bp_rnd;
  logic                bp_en;
  string               test_name;
  int                  err_cnt = 0;
  int                  test_err_base = 0;
  int                  check_cnt = 0;
  int                  test_cnt = 0;
  int                  insn_cnt = 0;
  int                  done_cnt = 0;
  int                  cycle_cnt = 0;

  always #20 clk = ~clk;

  lane u_lane (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_op_i    (req_op),
    .req_sew_i   (req_sew),
    .req_vd_i    (req_vd),
    .req_vs1_i   (req_vs1),
    .req_vs2_i   (req_vs2),
    .req_vl_i    (req_vl),
    .resp_done_o (resp_done),
    .ld_valid_i  (ld_valid),
    .ld_ready_o  (ld_ready),
    .ld_addr_i   (ld_addr),
    .ld_wdata_i  (ld_wdata),
    .st_valid_o  (st_valid),
    .st_ready_i  (st_ready),
    .st_data_o   (st_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Low bits of every result, 32-bit halves never carry into each other
  function automatic logic [ELEN-1:0] ref_exec(input lane_op_e op, input sew_e sew,
                                              input logic [ELEN-1:0] a,
                                              input logic [ELEN-1:0] b);
    logic [ELEN-1:0] r;
    logic [31:0]     ah;
    logic [31:0]     bh;
    r = a;
    if (sew == SEW_64) begin
      case (op)
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_AND:  r = a & b;
        OP_XOR:  r = a ^ b;
        OP_MUL:  r = a * b;
        default: r = a;
      endcase
    end else begin
      for (int h = 0; h < 2; h++) begin
        ah = a[h*32 +: 32];
        bh = b[h*32 +: 32];
        case (op)
          OP_ADD:  r[h*32 +: 32] = ah + bh;
          OP_SUB:  r[h*32 +: 32] = ah - bh;
          OP_AND:  r[h*32 +: 32] = ah & bh;
          OP_XOR:  r[h*32 +: 32] = ah ^ bh;
          OP_MUL:  r[h*32 +: 32] = ah * bh;
          default: r[h*32 +: 32] = ah;
        endcase
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  // Fills one register through the load port, even words get all ones low
  task automatic load_reg(input int vreg, input bit carry_mix);
    logic [ELEN-1:0] w;
    for (int i = 0; i < WORDS_PER_VREG; i++) begin
      w = {$random(seed), $random(seed)};
      if (carry_mix && (i % 2 == 0)) begin
        w[31:0] = 32'hffff_ffff;
      end
      @(negedge clk);
      ld_valid = 1'b1;
      ld_addr  = VADDR_W'(vreg * WORDS_PER_VREG + i);
      ld_wdata = w;
      @(posedge clk);
      while (!ld_ready) @(posedge clk);
      shadow[vreg*WORDS_PER_VREG + i] = w;
    end
    @(negedge clk);
    ld_valid = 1'b0;
  endtask

  task automatic wait_done();
    @(posedge clk);
    while (!resp_done) @(posedge clk);
  endtask

  // Issues one instruction and waits for its done pulse
  task automatic run_insn(input lane_op_e op, input sew_e sew, input int vd,
                          input int vs1, input int vs2, input int vl);
    logic [ELEN-1:0] res [WORDS_PER_VREG];
    for (int i = 0; i < vl; i++) begin
      res[i] = ref_exec(op, sew, shadow[vs1*WORDS_PER_VREG + i],
                        shadow[vs2*WORDS_PER_VREG + i]);
      if (op == OP_STORE) begin
        st_expect.push_back(shadow[vs1*WORDS_PER_VREG + i]);
      end
    end
    @(negedge clk);
    req_valid = 1'b1;
    req_op    = op;
    req_sew   = sew;
    req_vd    = VREG_W'(vd);
    req_vs1   = VREG_W'(vs1);
    req_vs2   = VREG_W'(vs2);
    req_vl    = VL_W'(vl);
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    @(negedge clk);
    req_valid = 1'b0;
    wait_done();
    if (op != OP_STORE) begin
      for (int i = 0; i < vl; i++) begin
        shadow[vd*WORDS_PER_VREG + i] = res[i];
      end
    end else if (st_expect.size() != 0) begin
      $display("Error in %s: store of v%0d finished with %0d words never sent",
               test_name, vs1, st_expect.size());
      err_cnt++;
      st_expect.delete();
    end
    insn_cnt++;
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("Test %s done with %0d errors", test_name, err_cnt - test_err_base);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and run limit
  ////////////////////////////////////////////////////////////////////////////

  // Every store transfer against the shadow copy
  always @(posedge clk) begin
    if (st_valid && st_ready) begin
      check_cnt++;
      if (st_expect.size() == 0) begin
        $display("Error in %s: store word %h arrived with none expected", test_name, st_data);
        err_cnt++;
      end else begin
        st_exp_word = st_expect.pop_front();
        if (st_data !== st_exp_word) begin
          $display("[FAIL] %s expected %h actual %h", test_name, st_exp_word, st_data);
          err_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (resp_done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  // Random store back-pressure
  always @(negedge clk) begin
    if (bp_en) begin
      bp_rnd   = $random(bp_seed);
      st_ready = bp_rnd[0];
    end else begin
      st_ready = 1'b1;
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= MAX_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    lane_op_e alu_ops [4];
    sew_e     widths [2];
    int       done_base;
    alu_ops   = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
    widths    = '{SEW_32, SEW_64};
    seed      = 32'hb45a_efa2;
    bp_seed   = 32'hb45a_efa2;
    bp_en     = 1'b0;
    clk       = 1'b0;
    arst_n    = 1'b1;
    req_valid = 1'b0;
    req_op    = OP_ADD;
    req_sew   = SEW_64;
    req_vd    = '0;
    req_vs1   = '0;
    req_vs2   = '0;
    req_vl    = '0;
    ld_valid  = 1'b0;
    ld_addr   = '0;
    ld_wdata  = '0;
    st_ready  = 1'b1;
    for (int i = 0; i < NR_VREGS*WORDS_PER_VREG; i++) begin
      shadow[i] = '0;
    end
    #5 arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;

    start_test("load_store");
    load_reg(1, 1'b0);
    run_insn(OP_STORE, SEW_64, 0, 1, 0, 8);
    end_test();

    start_test("alu_ops");
    load_reg(2, 1'b1);
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < 4; k++) begin
        run_insn(alu_ops[k], widths[s], 3, 1, 2, 8);
        run_insn(OP_STORE, SEW_64, 0, 3, 0, 8);
      end
    end
    end_test();

    start_test("mul");
    for (int s = 0; s < 2; s++) begin
      run_insn(OP_MUL, widths[s], 4, 1, 2, 8);
      run_insn(OP_STORE, SEW_64, 0, 4, 0, 8);
    end
    end_test();

    start_test("store_backpressure");
    bp_en = 1'b1;
    run_insn(OP_STORE, SEW_64, 0, 1, 0, 8);
    run_insn(OP_STORE, SEW_64, 0, 4, 0, 8);
    bp_en = 1'b0;
    end_test();

    // Load stream into v6 against a multiply into v5
    start_test("writeback_arb");
    @(negedge clk);
    done_base = done_cnt;
    fork
      run_insn(OP_MUL, SEW_64, 5, 1, 2, 8);
      load_reg(6, 1'b0);
    join
    run_insn(OP_STORE, SEW_64, 0, 5, 0, 8);
    run_insn(OP_STORE, SEW_64, 0, 6, 0, 8);
    repeat (4) @(negedge clk);
    check_cnt++;
    if (done_cnt - done_base != 3) begin
      $display("[FAIL] %s done pulses expected 3 actual %0d", test_name, done_cnt - done_base);
      err_cnt++;
    end
    end_test();

    // Words past vl keep the loaded values
    start_test("vector_length");
    load_reg(7, 1'b0);
    run_insn(OP_ADD, SEW_64, 7, 1, 2, 1);
    run_insn(OP_STORE, SEW_64, 0, 7, 0, 8);
    run_insn(OP_MUL, SEW_32, 7, 1, 2, 8);
    run_insn(OP_STORE, SEW_64, 0, 7, 0, 8);
    run_insn(OP_STORE, SEW_64, 0, 7, 0, 1);
    end_test();

    repeat (4) @(negedge clk);
    check_cnt++;
    if (done_cnt != insn_cnt) begin
      $display("[FAIL] done_count expected %0d actual %0d", insn_cnt, done_cnt);
      err_cnt++;
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
lane_cfg_pkg.sv
lane_insn_pkg.sv
lane_alu.sv
lane_mul.sv
lane_vrf.sv
lane_sequencer.sv
lane.sv
lane_sva.sv
tb_lane.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP      := tb_lane
FILELIST := all.f
PASS_MSG := Finished with no errors

.PHONY: sim clean

# Build and run, pass only when the pass message is printed
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
